// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// operand and result width, one machine word
`define DATA_WIDTH 32

// architectural registers, register 0 reads as zero
`define REG_COUNT 32

// cycles the result needs after the operands reach the ALU
// stands in for the ripple-carry settling time
`define ALU_SETTLE_CYCLES 4

`endif

// File: design/aluPkg.sv
package aluPkg;

	// ALU command, values follow the ALU control table
	typedef enum logic [2:0] {
		CMD_ADD  = 3'd0,
		CMD_SUB  = 3'd1,
		CMD_XOR  = 3'd2,
		CMD_SLT  = 3'd3,
		CMD_AND  = 3'd4,
		CMD_NAND = 3'd5,
		CMD_NOR  = 3'd6,
		CMD_OR   = 3'd7
	} aluCmd_t;

	// result source picked inside every slice
	typedef enum logic [2:0] {
		SEL_SUM  = 3'd0, // adder output, also used by SUB
		SEL_XOR  = 3'd2,
		SEL_LESS = 3'd3, // slice less input
		SEL_AND  = 3'd4,
		SEL_NAND = 3'd5,
		SEL_NOR  = 3'd6,
		SEL_OR   = 3'd7
	} muxSel_t;

endpackage

// File: design/isaPkg.sv
package isaPkg;

	// major opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08; // sign-extended
	localparam logic [5:0] OP_SLTI  = 6'h0a; // sign-extended
	localparam logic [5:0] OP_ANDI  = 6'h0c; // zero-extended
	localparam logic [5:0] OP_ORI   = 6'h0d; // zero-extended
	localparam logic [5:0] OP_XORI  = 6'h0e; // zero-extended

	// funct codes of the R-type word
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_NAND = 6'h2c; // no MIPS equivalent
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_OR   = 6'h25;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iType_t;

	// one instruction word, two field layouts
	typedef union packed {
		rType_t rFields;
		iType_t iFields;
	} instr_t;

endpackage

// File: design/alu.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] operandA,
	input  logic [`DATA_WIDTH-1:0] operandB,
	input  aluPkg::aluCmd_t        command,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   carryout,
	output logic                   overflow,
	output logic                   zero
);

	import aluPkg::*;

	localparam int width = `DATA_WIDTH;

	muxSel_t           muxSel;  // shared by all slices
	logic              invertB; // also the carry into bit 0
	logic [width-1:0]  bMod;    // B after optional inversion
	logic [width-1:0]  sum;
	logic [width:0]    carry;
	logic [width-1:0]  lessIn;
	logic              sltBit;

	// command lookup table
	always_comb begin
		case (command)
			CMD_ADD: begin
				muxSel  = SEL_SUM;
				invertB = 1'b0;
			end
			CMD_SUB: begin
				muxSel  = SEL_SUM;
				invertB = 1'b1;
			end
			CMD_XOR: begin
				muxSel  = SEL_XOR;
				invertB = 1'b0;
			end
			CMD_SLT: begin
				muxSel  = SEL_LESS;
				invertB = 1'b1; // A minus B decides the sign
			end
			CMD_AND: begin
				muxSel  = SEL_AND;
				invertB = 1'b0;
			end
			CMD_NAND: begin
				muxSel  = SEL_NAND;
				invertB = 1'b0;
			end
			CMD_NOR: begin
				muxSel  = SEL_NOR;
				invertB = 1'b0;
			end
			default: begin
				muxSel  = SEL_OR;
				invertB = 1'b0;
			end
		endcase
	end

	// one slice output stage
	function automatic logic sliceOut(input muxSel_t sel, input logic s, input logic a,
			input logic b, input logic less);
		case (sel)
			SEL_SUM:  return s;
			SEL_XOR:  return a ^ b;
			SEL_LESS: return less;
			SEL_AND:  return a & b;
			SEL_NAND: return ~(a & b);
			SEL_NOR:  return ~(a | b);
			SEL_OR:   return a | b;
			default:  return s;
		endcase
	endfunction

	assign carry[0] = invertB; // +1 completes the two's complement
	assign lessIn   = {{(width-1){1'b0}}, sltBit}; // only slice 0 gets the set bit

	genvar i;
	for (i = 0; i < width; i++) begin : gSlice
		assign bMod[i]    = operandB[i] ^ invertB;
		assign sum[i]     = operandA[i] ^ bMod[i] ^ carry[i];
		assign carry[i+1] = (operandA[i] & bMod[i]) | (carry[i] & (operandA[i] ^ bMod[i]));
		assign result[i]  = sliceOut(muxSel, sum[i], operandA[i], operandB[i], lessIn[i]);
	end

	// top slice extras
	assign carryout = carry[width];
	assign overflow = carry[width] ^ carry[width-1];
	assign sltBit   = sum[width-1] ^ overflow; // true sign of A minus B

	assign zero = ~|result;

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module regFile (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [$clog2(`REG_COUNT)-1:0]  readAddrA,
	input  logic [$clog2(`REG_COUNT)-1:0]  readAddrB,
	output logic [`DATA_WIDTH-1:0]         readDataA,
	output logic [`DATA_WIDTH-1:0]         readDataB,
	input  logic                           writeEn,
	input  logic [$clog2(`REG_COUNT)-1:0]  writeAddr,
	input  logic [`DATA_WIDTH-1:0]         writeData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// register 0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// asynchronous reads
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// File: design/settleTimer.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module settleTimer (
	input  logic clk,
	input  logic rst,
	input  logic load,
	output logic done
);

	localparam int countWidth = $clog2(`ALU_SETTLE_CYCLES + 2);

	logic [countWidth-1:0] count;
	logic                  busy; // keeps done low while idle

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			busy  <= 1'b0;
		end else if (load) begin
			count <= countWidth'(`ALU_SETTLE_CYCLES);
			busy  <= 1'b1;
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0; // done lasts one cycle
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign done = busy && (count == '0);

endmodule

// File: design/execController.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module execController (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instrValid,
	input  isaPkg::instr_t                 instrWord,
	output logic                           ready,
	output logic [$clog2(`REG_COUNT)-1:0]  readAddrA,
	output logic [$clog2(`REG_COUNT)-1:0]  readAddrB,
	output aluPkg::aluCmd_t                aluCommand,
	output logic                           useImm,
	output logic [`DATA_WIDTH-1:0]         immValue,
	output logic                           timerLoad,
	input  logic                           timerDone,
	output logic                           writeEn,
	output logic [$clog2(`REG_COUNT)-1:0]  writeAddr,
	output logic                           flagCapture,
	output logic                           wbValid
);

	import aluPkg::*;
	import isaPkg::*;

	localparam logic [1:0] stIdle   = 2'd0;
	localparam logic [1:0] stDecode = 2'd1;
	localparam logic [1:0] stSettle = 2'd2;
	localparam logic [1:0] stRetire = 2'd3;

	logic [1:0]                     state;
	instr_t                         instrReg; // word held from accept to decode
	aluCmd_t                        decCmd;
	logic                           decUseImm;
	logic                           decSignExt;
	logic [$clog2(`REG_COUNT)-1:0]  decDest;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle:   if (instrValid) state <= stDecode;
				stDecode: state <= stSettle;
				stSettle: if (timerDone) state <= stRetire;
				default:  state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stIdle && instrValid) begin
			instrReg <= instrWord;
		end
	end

	// opcode and funct to command
	always_comb begin
		decCmd     = CMD_ADD;
		decUseImm  = 1'b1;
		decSignExt = 1'b0;
		decDest    = instrReg.iFields.rt; // I-type writes rt
		case (instrReg.iFields.opcode)
			OP_RTYPE: begin
				decUseImm = 1'b0;
				decDest   = instrReg.rFields.rd;
				case (instrReg.rFields.funct)
					FN_SUB:  decCmd = CMD_SUB;
					FN_XOR:  decCmd = CMD_XOR;
					FN_SLT:  decCmd = CMD_SLT;
					FN_AND:  decCmd = CMD_AND;
					FN_NAND: decCmd = CMD_NAND;
					FN_NOR:  decCmd = CMD_NOR;
					FN_OR:   decCmd = CMD_OR;
					default: decCmd = CMD_ADD; // FN_ADD and unknown codes
				endcase
			end
			OP_ADDI: decSignExt = 1'b1;
			OP_SLTI: begin
				decCmd     = CMD_SLT;
				decSignExt = 1'b1;
			end
			OP_ANDI: decCmd = CMD_AND;
			OP_ORI:  decCmd = CMD_OR;
			OP_XORI: decCmd = CMD_XOR;
			default: decUseImm = 1'b0; // unknown opcode runs as R-type add
		endcase
	end

	// decoded operands registered as the timer loads
	always_ff @(posedge clk) begin
		if (rst) begin
			readAddrA  <= '0;
			readAddrB  <= '0;
			writeAddr  <= '0;
			aluCommand <= CMD_ADD;
			useImm     <= 1'b0;
		end else if (state == stDecode) begin
			readAddrA  <= instrReg.rFields.rs;
			readAddrB  <= instrReg.rFields.rt;
			writeAddr  <= decDest;
			aluCommand <= decCmd;
			useImm     <= decUseImm;
		end
	end

	always_ff @(posedge clk) begin
		if (state == stDecode) begin
			immValue <= decSignExt
				? {{(`DATA_WIDTH-16){instrReg.iFields.imm16[15]}}, instrReg.iFields.imm16}
				: {{(`DATA_WIDTH-16){1'b0}}, instrReg.iFields.imm16};
		end
	end

	assign ready       = (state == stIdle);
	assign timerLoad   = (state == stDecode);
	assign writeEn     = (state == stRetire);
	assign flagCapture = (state == stRetire);
	assign wbValid     = (state == stRetire);

endmodule

// File: design/execCore.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module execCore (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           instrValid,
	input  logic [`DATA_WIDTH-1:0]         instrWord,
	output logic                           ready,
	output logic                           wbValid,
	output logic [$clog2(`REG_COUNT)-1:0]  wbAddr,
	output logic [`DATA_WIDTH-1:0]         wbData,
	output logic                           carryFlag,
	output logic                           overflowFlag,
	output logic                           zeroFlag
);

	import aluPkg::*;

	localparam int addrWidth = $clog2(`REG_COUNT);

	logic [addrWidth-1:0]     readAddrA;
	logic [addrWidth-1:0]     readAddrB;
	logic [`DATA_WIDTH-1:0]   readDataA;
	logic [`DATA_WIDTH-1:0]   readDataB;
	aluCmd_t                  aluCommand;
	logic                     useImm;
	logic [`DATA_WIDTH-1:0]   immValue;
	logic [`DATA_WIDTH-1:0]   operandB;
	logic                     timerLoad;
	logic                     timerDone;
	logic                     writeEn;
	logic                     flagCapture;
	logic [`DATA_WIDTH-1:0]   aluResult;
	logic                     aluCarry;
	logic                     aluOverflow;
	logic                     aluZero;

	execController ctrl0 (
		.clk         (clk),
		.rst         (rst),
		.instrValid  (instrValid),
		.instrWord   (instrWord),
		.ready       (ready),
		.readAddrA   (readAddrA),
		.readAddrB   (readAddrB),
		.aluCommand  (aluCommand),
		.useImm      (useImm),
		.immValue    (immValue),
		.timerLoad   (timerLoad),
		.timerDone   (timerDone),
		.writeEn     (writeEn),
		.writeAddr   (wbAddr),
		.flagCapture (flagCapture),
		.wbValid     (wbValid)
	);

	settleTimer timer0 (
		.clk  (clk),
		.rst  (rst),
		.load (timerLoad),
		.done (timerDone)
	);

	regFile regs0 (
		.clk       (clk),
		.rst       (rst),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.writeEn   (writeEn),
		.writeAddr (wbAddr),
		.writeData (aluResult)
	);

	assign operandB = useImm ? immValue : readDataB; // I-type takes the extended immediate

	alu alu0 (
		.operandA (readDataA),
		.operandB (operandB),
		.command  (aluCommand),
		.result   (aluResult),
		.carryout (aluCarry),
		.overflow (aluOverflow),
		.zero     (aluZero)
	);

	assign wbData = aluResult;

	// flags follow the retiring instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			carryFlag    <= 1'b0;
			overflowFlag <= 1'b0;
			zeroFlag     <= 1'b0;
		end else if (flagCapture) begin
			carryFlag    <= aluCarry;
			overflowFlag <= aluOverflow;
			zeroFlag     <= aluZero;
		end
	end

endmodule

// File: tests/execCore_assertions.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module execCore_assertions (
	input logic                           clk,
	input logic                           rst,
	input logic                           instrValid,
	input isaPkg::instr_t                 instrWord,
	input logic                           ready,
	input logic                           wbValid,
	input logic [$clog2(`REG_COUNT)-1:0]  wbAddr,
	input logic [`DATA_WIDTH-1:0]         wbData,
	input logic                           carryFlag,
	input logic                           overflowFlag,
	input logic                           zeroFlag
);

	import isaPkg::*;

	localparam int w       = `DATA_WIDTH;
	localparam int latency = `ALU_SETTLE_CYCLES + 2; // edges from accept to wbValid

	logic [w-1:0] shadow [`REG_COUNT]; // reference register file
	logic [w-1:0] opA;
	logic [w-1:0] opB;
	logic [w-1:0] immExt;
	logic [w:0]   wide;                // carry out on top
	logic [w-1:0] nData;
	logic [4:0]   nAddr;
	logic         nCarry;
	logic         nOvf;
	logic         nArith;
	logic [w-1:0] expData;
	logic [4:0]   expAddr;
	logic         expCarry;
	logic         expOvf;
	logic         expArith;            // carry and overflow only checked for add and sub
	logic         accept;
	logic         pending;
	int           count;
	int           failCount;

	initial failCount = 0;

	function automatic logic [w:0] addWithCarry(input logic [w-1:0] a, input logic [w-1:0] b,
			input logic cin);
		return {1'b0, a} + {1'b0, b} + {{w{1'b0}}, cin};
	endfunction

	assign accept = instrValid && ready && !rst;

	// expected outcome of the word on the input, from the shadow registers
	always_comb begin
		opA    = shadow[instrWord.rFields.rs];
		opB    = shadow[instrWord.rFields.rt];
		immExt = {{(w-16){1'b0}}, instrWord.iFields.imm16};
		nAddr  = instrWord.iFields.rt;
		nArith = 1'b0;
		if (instrWord.iFields.opcode == OP_ADDI || instrWord.iFields.opcode == OP_SLTI) begin
			immExt = {{(w-16){instrWord.iFields.imm16[15]}}, instrWord.iFields.imm16};
		end
		if (instrWord.iFields.opcode != OP_RTYPE) begin
			opB = immExt;
		end else begin
			nAddr = instrWord.rFields.rd;
		end
		wide  = addWithCarry(opA, opB, 1'b0);
		nData = wide[w-1:0];
		case (instrWord.iFields.opcode)
			OP_RTYPE: begin
				case (instrWord.rFields.funct)
					FN_SUB: begin
						wide   = addWithCarry(opA, ~opB, 1'b1); // carry set means no borrow
						nData  = wide[w-1:0];
						nArith = 1'b1;
					end
					FN_XOR:  nData = opA ^ opB;
					FN_SLT:  nData = {{(w-1){1'b0}}, ($signed(opA) < $signed(opB))};
					FN_AND:  nData = opA & opB;
					FN_NAND: nData = ~(opA & opB);
					FN_NOR:  nData = ~(opA | opB);
					FN_OR:   nData = opA | opB;
					default: nArith = 1'b1;
				endcase
			end
			OP_SLTI: nData = {{(w-1){1'b0}}, ($signed(opA) < $signed(opB))};
			OP_ANDI: nData = opA & opB;
			OP_ORI:  nData = opA | opB;
			OP_XORI: nData = opA ^ opB;
			default: nArith = 1'b1;
		endcase
		nCarry = wide[w];
		// signed overflow when the operand signs agree and the sum sign differs
		if (nArith && instrWord.rFields.funct == FN_SUB && instrWord.iFields.opcode == OP_RTYPE) begin
			nOvf = (opA[w-1] != opB[w-1]) && (nData[w-1] != opA[w-1]);
		end else begin
			nOvf = (opA[w-1] == opB[w-1]) && (nData[w-1] != opA[w-1]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			expData  <= '0;
			expAddr  <= '0;
			expCarry <= 1'b0;
			expOvf   <= 1'b0;
			expArith <= 1'b0;
		end else if (accept) begin
			expData  <= nData;
			expAddr  <= nAddr;
			expCarry <= nCarry;
			expOvf   <= nOvf;
			expArith <= nArith;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `REG_COUNT; r++) begin
				shadow[r] <= '0;
			end
		end else if (wbValid && expAddr != 5'd0) begin
			shadow[expAddr] <= expData; // register 0 stays zero
		end
	end

	// edges since the accepting edge
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			count   <= 0;
		end else if (accept) begin
			pending <= 1'b1;
			count   <= 0;
		end else if (wbValid) begin
			pending <= 1'b0;
		end else if (pending) begin
			count <= count + 1;
		end
	end

	resultCheck: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> wbData == expData && wbAddr == expAddr)
		else begin
			$error("ERROR %0t: writeback r%0d=%h, expected r%0d=%h", $time, wbAddr, wbData,
				expAddr, expData);
			failCount++;
		end

	latencyCheck: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> pending && count == latency)
		else begin
			$error("ERROR %0t: wbValid at the wrong cycle or without an accept", $time);
			failCount++;
		end

	pulseCheck: assert property (@(posedge clk) disable iff (rst)
		wbValid |=> ready && !wbValid)
		else begin
			$error("ERROR %0t: wbValid longer than one cycle or ready not back", $time);
			failCount++;
		end

	busyCheck: assert property (@(posedge clk) disable iff (rst)
		pending |-> !ready)
		else begin
			$error("ERROR %0t: ready high while an instruction is in flight", $time);
			failCount++;
		end

	arithFlagCheck: assert property (@(posedge clk) disable iff (rst)
		wbValid && expArith |=> carryFlag == expCarry && overflowFlag == expOvf)
		else begin
			$error("ERROR %0t: carry %b overflow %b, expected %b %b", $time, carryFlag,
				overflowFlag, expCarry, expOvf);
			failCount++;
		end

	zeroFlagCheck: assert property (@(posedge clk) disable iff (rst)
		wbValid |=> zeroFlag == (expData == '0))
		else begin
			$error("ERROR %0t: zeroFlag %b for result %h", $time, zeroFlag, expData);
			failCount++;
		end

endmodule

bind execCore execCore_assertions chk0 (.*);

// File: tests/execCore_tb.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module execCore_tb;

	import isaPkg::*;

	localparam int instrBudget = 120; // upper bound on issued instructions
	localparam int watchdogNs  = instrBudget * (`ALU_SETTLE_CYCLES + 4) * 8 + 8 * 8 + 1000;
	localparam logic [5:0] functList [8] = '{FN_ADD, FN_SUB, FN_XOR, FN_SLT, FN_AND, FN_NAND,
		FN_NOR, FN_OR};
	localparam logic [5:0] iOps [5] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};

	logic        clk;
	logic        rst;
	logic        instrValid;
	logic [31:0] instrWord;
	logic        ready;
	logic        wbValid;
	logic [4:0]  wbAddr;
	logic [31:0] wbData;
	logic        carryFlag;
	logic        overflowFlag;
	logic        zeroFlag;
	integer      seed;
	int          instrCount;
	int          testCount;
	int          testStartInstr;
	int          testStartFail;

	execCore dut0 (
		.clk          (clk),
		.rst          (rst),
		.instrValid   (instrValid),
		.instrWord    (instrWord),
		.ready        (ready),
		.wbValid      (wbValid),
		.wbAddr       (wbAddr),
		.wbData       (wbData),
		.carryFlag    (carryFlag),
		.overflowFlag (overflowFlag),
		.zeroFlag     (zeroFlag)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired, the core stopped retiring instructions");
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] rTypeWord(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// called 1 ns after an edge
	task automatic waitReady();
		while (!ready) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic issue(input logic [31:0] word);
		waitReady();
		instrValid = 1'b1;
		instrWord  = word;
		@(posedge clk); // accepting edge
		#1;
		instrValid = 1'b0;
		instrCount++;
	endtask

	// extra strobes while the core is busy must be ignored
	task automatic issueWithStrobes(input logic [31:0] word, input logic [31:0] junk);
		issue(word);
		instrValid = 1'b1;
		instrWord  = junk;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		instrValid = 1'b0;
	endtask

	task automatic endTest(input string name);
		waitReady();
		@(posedge clk); // flags are checked one edge after wbValid
		#1;
		testCount++;
		$display("%s: %0d instructions, %0d assertion failures", name,
			instrCount - testStartInstr, dut0.chk0.failCount - testStartFail);
		testStartInstr = instrCount;
		testStartFail  = dut0.chk0.failCount;
	endtask

	initial begin
		logic [31:0] rnd;
		seed           = 32'hedf;
		rst            = 1'b1;
		instrValid     = 1'b0;
		instrWord      = '0;
		instrCount     = 0;
		testCount      = 0;
		testStartInstr = 0;
		testStartFail  = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 1; r <= 8; r++) begin
			rnd = $random(seed);
			issue(iTypeWord((r % 2) == 1 ? OP_ADDI : OP_ORI, 5'(r), 5'd0, rnd[31:16]));
		end
		endTest("immediate loads");

		for (int f = 0; f < 8; f++) begin
			for (int k = 0; k < 4; k++) begin
				rnd = $random(seed);
				issue(rTypeWord(functList[f], rnd[9:5], {2'b00, rnd[2:0]} + 5'd1,
					{2'b00, rnd[14:12]} + 5'd1));
			end
		end
		endTest("r-type functions");

		issue(iTypeWord(OP_ADDI, 5'd20, 5'd0, 16'h4000));
		repeat (17) issue(rTypeWord(FN_ADD, 5'd20, 5'd20, 5'd20)); // doubles up to 0x80000000
		issue(rTypeWord(FN_NOR, 5'd21, 5'd20, 5'd0));             // 0x7fffffff
		issue(iTypeWord(OP_ADDI, 5'd24, 5'd0, 16'd1));
		issue(rTypeWord(FN_SLT, 5'd22, 5'd20, 5'd21));
		issue(rTypeWord(FN_SLT, 5'd23, 5'd21, 5'd20));
		issue(rTypeWord(FN_SLT, 5'd25, 5'd20, 5'd24));
		issue(iTypeWord(OP_SLTI, 5'd26, 5'd21, 16'hffff));
		issue(iTypeWord(OP_SLTI, 5'd27, 5'd20, 16'h0001));
		issue(rTypeWord(FN_ADD, 5'd30, 5'd21, 5'd24));            // positive overflow
		issue(rTypeWord(FN_SUB, 5'd31, 5'd20, 5'd24));            // negative overflow
		endTest("set-less-than");

		for (int k = 0; k < 8; k++) begin
			rnd = $random(seed);
			issue(iTypeWord(iOps[rnd[18:16] % 3'd5], rnd[4:0], rnd[9:5], rnd[31:16]));
		end
		endTest("latency");

		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			issueWithStrobes(rTypeWord(functList[rnd[2:0]], rnd[9:5], rnd[14:10], rnd[19:15]),
				$random(seed));
		end
		endTest("ignored strobes");

		issue(iTypeWord(OP_ADDI, 5'd0, 5'd0, 16'd5));
		issue(rTypeWord(FN_ADD, 5'd0, 5'd21, 5'd24));
		issue(rTypeWord(FN_ADD, 5'd28, 5'd0, 5'd0));
		issue(rTypeWord(FN_OR, 5'd29, 5'd0, 5'd20));
		issue(iTypeWord(OP_SLTI, 5'd2, 5'd0, 16'd1));
		endTest("register 0");

		$display("summary: %0d tests, %0d instructions, %0d assertion failures", testCount,
			instrCount, dut0.chk0.failCount);
		if (dut0.chk0.failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+design
design/aluPkg.sv
design/isaPkg.sv
design/alu.sv
design/regFile.sv
design/settleTimer.sv
design/execController.sv
design/execCore.sv
tests/execCore_assertions.sv
tests/execCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module execCore_tb -o execCore_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/execCore_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi
